/* vmadd.f */
+incdir+rtl
rtl/vmadd_pkg.sv
rtl/vmadd_byte_lane.sv
rtl/vmadd_operand_feed.sv
rtl/vmadd_result_collect.sv
rtl/vmadd_top.sv
verif/vmadd_chk.sv
verif/vmadd_tb.sv

/* Bender.yml */
package:
  name: vmadd

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vmadd_pkg.sv
      - rtl/vmadd_byte_lane.sv
      - rtl/vmadd_operand_feed.sv
      - rtl/vmadd_result_collect.sv
      - rtl/vmadd_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/vmadd_chk.sv
      - verif/vmadd_tb.sv

/* verif/vmadd_tb.sv */
`timescale 1ns/1ps

module vmadd_tb;

	localparam int CLK_PERIOD = 40;
	localparam int N_DIRECTED = 12;
	localparam int N_RANDOM = 40;
	localparam int N_ROWS = N_DIRECTED + N_RANDOM;
	// Per row bound, random stalls included.
	localparam int ROW_CYCLES = 16;
	localparam int SLACK_CYCLES = 40;
	localparam int WATCHDOG_NS = (N_ROWS * ROW_CYCLES + SLACK_CYCLES) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'h126a_dfe9;

	typedef struct {
		string name;
		vmadd_pkg::sew_t sew;
		vmadd_pkg::overwrite_t mode;
		logic sub;
		vmadd_pkg::vreg_t vs2;
		vmadd_pkg::vreg_t vs1;
		vmadd_pkg::vreg_t vdd;
		vmadd_pkg::vreg_t expected;
	} row_t;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	vmadd_pkg::sew_t sew;
	vmadd_pkg::overwrite_t overwrite_mode;
	logic sub_en;
	vmadd_pkg::vreg_t vs2;
	vmadd_pkg::vreg_t vs1;
	vmadd_pkg::vreg_t vdd;
	logic out_valid;
	logic out_ready;
	vmadd_pkg::vreg_t vd;

	row_t rows[$];
	row_t pending_q[$];
	row_t out_row;
	bit ready_pattern[256];
	logic [7:0] ready_cycle = 8'd0;
	int accepted = 0;
	int received = 0;
	int errors = 0;
	int checks = 0;

	vmadd_top dut
	(
		.clk (clk),
		.rst_n (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.sew (sew),
		.overwrite_mode (overwrite_mode),
		.sub_en (sub_en),
		.vs2 (vs2),
		.vs1 (vs1),
		.vdd (vdd),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.vd (vd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Each element is the addend plus or minus the low SEW bits of the product.
	function automatic vmadd_pkg::vreg_t expected_vd(input vmadd_pkg::sew_t s,
		input vmadd_pkg::overwrite_t m, input logic sb, input vmadd_pkg::vreg_t a2,
		input vmadd_pkg::vreg_t a1, input vmadd_pkg::vreg_t ad);
		int w;
		logic [63:0] mask;
		logic [63:0] mult;
		logic [63:0] acc;
		logic [63:0] p;
		logic [63:0] r;
		logic [63:0] res;
		w = (s == vmadd_pkg::SEW_8) ? 8 : (s == vmadd_pkg::SEW_16) ? 16 : 32;
		mask = (64'd1 << w) - 64'd1;
		mult = (m == vmadd_pkg::OVERWRITE_SECOND_OPERAND) ? a1 : ad;
		acc = (m == vmadd_pkg::OVERWRITE_SECOND_OPERAND) ? ad : a1;
		res = '0;
		for (int e = 0; e < 64 / w; e++)
		begin
			p = (((a2 >> (e * w)) & mask) * ((mult >> (e * w)) & mask)) & mask;
			r = sb ? ((acc >> (e * w)) - p) & mask : ((acc >> (e * w)) + p) & mask;
			res = res | (r << (e * w));
		end
		return res;
	endfunction

	task automatic add_row(input string name, input vmadd_pkg::sew_t s,
		input vmadd_pkg::overwrite_t m, input logic sb, input vmadd_pkg::vreg_t a2,
		input vmadd_pkg::vreg_t a1, input vmadd_pkg::vreg_t ad, input vmadd_pkg::vreg_t exp_vd);
		row_t r;
		r.name = name;
		r.sew = s;
		r.mode = m;
		r.sub = sb;
		r.vs2 = a2;
		r.vs1 = a1;
		r.vdd = ad;
		r.expected = exp_vd;
		rows.push_back(r);
	endtask

	task automatic build_table();
		vmadd_pkg::sew_t rs;
		vmadd_pkg::overwrite_t rm;
		logic rsub;
		vmadd_pkg::vreg_t r2;
		vmadd_pkg::vreg_t r1;
		vmadd_pkg::vreg_t rd;
		add_row("sew8 add all ones", vmadd_pkg::SEW_8, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b0,
			'1, '1, '1, 64'h0);
		add_row("sew8 add", vmadd_pkg::SEW_8, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b0,
			64'h0102_0304_0506_0708, 64'h0202_0202_0202_0202, 64'h1010_1010_1010_1010,
			64'h1214_1618_1A1C_1E20);
		add_row("sew16 add carry", vmadd_pkg::SEW_16, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b0,
			64'h00FF_00FF_00FF_00FF, 64'h0002_0002_0002_0002, 64'h0002_0002_0002_0002,
			64'h0200_0200_0200_0200);
		add_row("sew16 add all ones", vmadd_pkg::SEW_16, vmadd_pkg::OVERWRITE_SECOND_OPERAND,
			1'b0, '1, '1, '1, 64'h0);
		add_row("sew32 add", vmadd_pkg::SEW_32, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b0,
			64'h0001_0000_0000_FFFF, 64'h0001_0000_0000_0003, 64'hFFFF_FFFF_0000_0001,
			64'hFFFF_FFFF_0002_FFFE);
		add_row("sew32 add all ones", vmadd_pkg::SEW_32, vmadd_pkg::OVERWRITE_SECOND_OPERAND,
			1'b0, '1, '1, '1, 64'h0);
		add_row("sew8 sub", vmadd_pkg::SEW_8, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b1,
			64'h0102_0304_0506_0708, 64'h0202_0202_0202_0202, 64'h1010_1010_1010_1000,
			64'h0E0C_0A08_0604_02F0);
		add_row("sew16 sub", vmadd_pkg::SEW_16, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b1,
			64'h0003_0100_0010_0001, 64'h0005_0002_0010_0001, 64'h0000_0300_0000_1234,
			64'hFFF1_0100_FF00_1233);
		add_row("sew32 sub", vmadd_pkg::SEW_32, vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b1,
			64'h0000_1000_0000_0002, 64'h0001_0000_0000_0003, 64'h0000_0000_0000_0005,
			64'hF000_0000_FFFF_FFFF);
		add_row("sew8 add destination", vmadd_pkg::SEW_8, vmadd_pkg::OVERWRITE_DESTINATION, 1'b0,
			64'h0102_0304_0506_0708, 64'h0202_0202_0202_0202, 64'h1010_1010_1010_1010,
			64'h1222_3242_5262_7282);
		add_row("sew16 sub destination", vmadd_pkg::SEW_16, vmadd_pkg::OVERWRITE_DESTINATION,
			1'b1, 64'h0002_0002_0002_0002, 64'h0100_0100_0100_0100, 64'h0001_0010_0080_00FF,
			64'h00FE_00E0_0000_FF02);
		add_row("sew16 sub second operand", vmadd_pkg::SEW_16,
			vmadd_pkg::OVERWRITE_SECOND_OPERAND, 1'b1, 64'h0002_0002_0002_0002,
			64'h0100_0100_0100_0100, 64'h0001_0010_0080_00FF, 64'hFE01_FE10_FE80_FEFF);
		for (int i = 0; i < N_RANDOM; i++)
		begin
			rs = vmadd_pkg::sew_t'($urandom % 3);
			rm = vmadd_pkg::overwrite_t'($urandom % 2);
			rsub = $urandom % 2;
			r2 = {$urandom, $urandom};
			r1 = {$urandom, $urandom};
			rd = {$urandom, $urandom};
			add_row($sformatf("random %0d", i), rs, rm, rsub, r2, r1, rd,
				expected_vd(rs, rm, rsub, r2, r1, rd));
		end
	endtask

	// Called on a rising edge; returns on the edge that takes the row.
	task automatic send_row(input row_t r);
		in_valid <= 1'b1;
		sew <= r.sew;
		overwrite_mode <= r.mode;
		sub_en <= r.sub;
		vs2 <= r.vs2;
		vs1 <= r.vs1;
		vdd <= r.vdd;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
	endtask

	// Sink stalls randomly once the directed rows are in.
	always @(posedge clk)
	begin
		if (accepted < N_DIRECTED)
			out_ready <= 1'b1;
		else
			out_ready <= ready_pattern[ready_cycle];
		ready_cycle <= ready_cycle + 8'd1;
	end

	// Transfers are counted mid-cycle, where the handshake is settled.
	always @(negedge clk)
	begin
		if (rst_n && out_valid && out_ready)
		begin
			if (pending_q.size() == 0)
			begin
				$display("error at %0t: result %h arrived with no input pending", $time, vd);
				errors++;
			end
			else
			begin
				out_row = pending_q.pop_front();
				checks++;
				if (vd !== out_row.expected)
				begin
					$display("error at %0t: vd expected %h, got %h (%s)", $time,
						out_row.expected, vd, out_row.name);
					errors++;
				end
				else
					$display("ok %s: vd %h", out_row.name, vd);
			end
			received++;
		end
		if (rst_n && in_valid && in_ready)
		begin
			pending_q.push_back(rows[accepted]);
			accepted++;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with %0d of %0d results in", WATCHDOG_NS,
			received, N_ROWS);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		sew = vmadd_pkg::SEW_8;
		overwrite_mode = vmadd_pkg::OVERWRITE_SECOND_OPERAND;
		sub_en = 1'b0;
		vs2 = '0;
		vs1 = '0;
		vdd = '0;
		out_ready = 1'b1;
		for (int i = 0; i < 256; i++)
			ready_pattern[i] = $urandom % 2;
		build_table();

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		checks += 2;
		if (out_valid !== 1'b0)
		begin
			$display("error at %0t: out_valid expected 0, got %b", $time, out_valid);
			errors++;
		end
		if (in_ready !== 1'b1)
		begin
			$display("error at %0t: in_ready expected 1, got %b", $time, in_ready);
			errors++;
		end
		$display("reset state checked");

		@(posedge clk);
		foreach (rows[i])
			send_row(rows[i]);
		in_valid <= 1'b0;

		wait (received == N_ROWS);
		repeat (2) @(posedge clk);
		if (accepted != N_ROWS || pending_q.size() != 0)
		begin
			$display("input count %0d does not match %0d rows or results are missing",
				accepted, N_ROWS);
			errors++;
		end

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			dut.u_chk.assert_failures);
		if (errors == 0 && dut.u_chk.assert_failures == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verif/vmadd_chk.sv */
`timescale 1ns/1ps

module vmadd_chk
(
	input logic clk,
	input logic rst_n,
	input logic out_valid,
	input logic out_ready,
	input vmadd_pkg::vreg_t vd
);

	int assert_failures = 0;

	// Output register empty right after reset.
	out_valid_cleared: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else
		begin
			$error("out_valid high in the cycle after reset");
			assert_failures++;
		end

	// Stalled result holds until taken.
	stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(vd)))
		else
		begin
			$error("vd or out_valid changed while stalled");
			assert_failures++;
		end

	// Valid results are fully known.
	vd_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(vd))
		else
		begin
			$error("vd has unknown bits while out_valid is high");
			assert_failures++;
		end

endmodule

bind vmadd_top vmadd_chk u_chk
(
	.clk (clk),
	.rst_n (rst_n),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.vd (vd)
);

/* rtl/vmadd_top.sv */
`timescale 1ns/1ps

`include "vmadd_cfg.svh"

module vmadd_top
(
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	output logic in_ready,
	input vmadd_pkg::sew_t sew,
	input vmadd_pkg::overwrite_t overwrite_mode,
	input logic sub_en,
	input vmadd_pkg::vreg_t vs2,
	input vmadd_pkg::vreg_t vs1,
	input vmadd_pkg::vreg_t vdd,

	output logic out_valid,
	input logic out_ready,
	output vmadd_pkg::vreg_t vd
);

	vmadd_pkg::vreg_t product;
	vmadd_pkg::vreg_t addend;
	vmadd_pkg::lane_mask_t elem_start;
	logic sub;
	logic stage_valid;
	logic advance;

	vmadd_pkg::vreg_t sums;

	// Top bit is the carry out of the last element, dropped on wrap.
	logic [`VMADD_LANES:0] carry;

	assign carry[0] = 1'b0;
	assign in_ready = advance;

	vmadd_operand_feed u_feed
	(
		.clk (clk),
		.rst_n (rst_n),
		.in_valid (in_valid),
		.sew (sew),
		.overwrite_mode (overwrite_mode),
		.sub_en (sub_en),
		.vs2 (vs2),
		.vs1 (vs1),
		.vdd (vdd),
		.advance (advance),
		.product (product),
		.addend (addend),
		.elem_start (elem_start),
		.sub (sub),
		.stage_valid (stage_valid)
	);

	genvar lane;

	// Segmented carry chain.
	generate
		for (lane = 0; lane < `VMADD_LANES; lane++)
		begin : g_lane
			vmadd_byte_lane u_lane
			(
				.product_byte (product[lane*`VMADD_BYTE +: `VMADD_BYTE]),
				.addend_byte (addend[lane*`VMADD_BYTE +: `VMADD_BYTE]),
				.elem_start (elem_start[lane]),
				.sub (sub),
				.carry_in (carry[lane]),
				.sum_byte (sums[lane*`VMADD_BYTE +: `VMADD_BYTE]),
				.carry_out (carry[lane+1])
			);
		end
	endgenerate

	vmadd_result_collect u_collect
	(
		.clk (clk),
		.rst_n (rst_n),
		.stage_valid (stage_valid),
		.sums (sums),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.vd (vd),
		.advance (advance)
	);

endmodule

/* rtl/vmadd_result_collect.sv */
`timescale 1ns/1ps

module vmadd_result_collect
(
	input logic clk,
	input logic rst_n,

	input logic stage_valid,
	input vmadd_pkg::vreg_t sums,

	input logic out_ready,
	output logic out_valid,
	output vmadd_pkg::vreg_t vd,

	output logic advance
);

	// Output register is free or is being taken this cycle.
	assign advance = !out_valid || out_ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else if (advance)
		begin
			out_valid <= stage_valid;
		end
	end

	// Result only moves on a real item.
	always_ff @(posedge clk)
	begin
		if (advance && stage_valid)
		begin
			vd <= sums;
		end
	end

endmodule

/* rtl/vmadd_operand_feed.sv */
`timescale 1ns/1ps

`include "vmadd_cfg.svh"

module vmadd_operand_feed
(
	input logic clk,
	input logic rst_n,

	input logic in_valid,
	input vmadd_pkg::sew_t sew,
	input vmadd_pkg::overwrite_t overwrite_mode,
	input logic sub_en,
	input vmadd_pkg::vreg_t vs2,
	input vmadd_pkg::vreg_t vs1,
	input vmadd_pkg::vreg_t vdd,

	input logic advance,

	output vmadd_pkg::vreg_t product,
	output vmadd_pkg::vreg_t addend,
	output vmadd_pkg::lane_mask_t elem_start,
	output logic sub,
	output logic stage_valid
);

	vmadd_pkg::vreg_t mult_src;
	vmadd_pkg::vreg_t addend_src;

	vmadd_pkg::vreg_t prod_8;
	vmadd_pkg::vreg_t prod_16;
	vmadd_pkg::vreg_t prod_32;

	vmadd_pkg::vreg_t product_next;
	vmadd_pkg::lane_mask_t start_next;

	// Operand roles.
	always_comb
	begin
		case (overwrite_mode)
			vmadd_pkg::OVERWRITE_SECOND_OPERAND:
			begin
				mult_src = vs1;
				addend_src = vdd;
			end

			vmadd_pkg::OVERWRITE_DESTINATION:
			begin
				mult_src = vdd;
				addend_src = vs1;
			end
		endcase
	end

	// Byte products, low 8 bits kept.
	always_comb
	begin
		for (int i = 0; i < `VMADD_VLEN / `VMADD_SEW8; i++)
		begin
			prod_8[i*`VMADD_SEW8 +: `VMADD_SEW8] =
				vs2[i*`VMADD_SEW8 +: `VMADD_SEW8] * mult_src[i*`VMADD_SEW8 +: `VMADD_SEW8];
		end
	end

	// Halfword products.
	always_comb
	begin
		for (int i = 0; i < `VMADD_VLEN / `VMADD_SEW16; i++)
		begin
			prod_16[i*`VMADD_SEW16 +: `VMADD_SEW16] =
				vs2[i*`VMADD_SEW16 +: `VMADD_SEW16] *
				mult_src[i*`VMADD_SEW16 +: `VMADD_SEW16];
		end
	end

	// Word products.
	always_comb
	begin
		for (int i = 0; i < `VMADD_VLEN / `VMADD_SEW32; i++)
		begin
			prod_32[i*`VMADD_SEW32 +: `VMADD_SEW32] =
				vs2[i*`VMADD_SEW32 +: `VMADD_SEW32] *
				mult_src[i*`VMADD_SEW32 +: `VMADD_SEW32];
		end
	end

	// Pick the product set and the lanes that open an element.
	always_comb
	begin
		case (sew)
			vmadd_pkg::SEW_8:
			begin
				product_next = prod_8;
				start_next = `VMADD_START_SEW8;
			end

			vmadd_pkg::SEW_16:
			begin
				product_next = prod_16;
				start_next = `VMADD_START_SEW16;
			end

			vmadd_pkg::SEW_32:
			begin
				product_next = prod_32;
				start_next = `VMADD_START_SEW32;
			end

			default:
			begin
				product_next = prod_8;
				start_next = `VMADD_START_SEW8;
			end
		endcase
	end

	// Stage occupancy.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			stage_valid <= 1'b0;
		end
		else if (advance)
		begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			product <= product_next;
			addend <= addend_src;
			elem_start <= start_next;
			sub <= sub_en;
		end
	end

endmodule

/* rtl/vmadd_byte_lane.sv */
`timescale 1ns/1ps

`include "vmadd_cfg.svh"

module vmadd_byte_lane
(
	input vmadd_pkg::lane_byte_t product_byte,
	input vmadd_pkg::lane_byte_t addend_byte,
	input logic elem_start,
	input logic sub,
	input logic carry_in,

	output vmadd_pkg::lane_byte_t sum_byte,
	output logic carry_out
);

	vmadd_pkg::lane_byte_t operand_byte;
	logic carry_eff;
	logic [`VMADD_BYTE:0] total;

	// Subtraction adds the inverted product plus one.
	assign operand_byte = sub ? ~product_byte : product_byte;

	// First byte of an element takes the injected carry,
	// the others take the carry from the lane below.
	assign carry_eff = elem_start ? sub : carry_in;

	assign total = addend_byte + operand_byte + carry_eff;

	assign sum_byte = total[`VMADD_BYTE-1:0];
	assign carry_out = total[`VMADD_BYTE];

endmodule

/* rtl/vmadd_pkg.sv */
`include "vmadd_cfg.svh"

package vmadd_pkg;

	// Full vector operand or result.
	typedef logic [`VMADD_VLEN-1:0] vreg_t;

	// One byte of a lane.
	typedef logic [`VMADD_BYTE-1:0] lane_byte_t;

	// One bit per lane.
	typedef logic [`VMADD_LANES-1:0] lane_mask_t;

	// Element width.
	typedef enum logic [1:0]
	{
		SEW_8 = 2'd0,
		SEW_16 = 2'd1,
		SEW_32 = 2'd2
	} sew_t;

	// Which operand feeds the multiplier and which the adder.
	// Second operand mode computes vs2 * vs1 + vdd.
	// Destination mode computes vs2 * vdd + vs1.
	typedef enum logic
	{
		OVERWRITE_SECOND_OPERAND = 1'b0,
		OVERWRITE_DESTINATION = 1'b1
	} overwrite_t;

endpackage

/* rtl/vmadd_cfg.svh */
`ifndef VMADD_CFG_SVH
`define VMADD_CFG_SVH

// Width of one vector register.
`define VMADD_VLEN 64

// Width of one adder lane.
`define VMADD_BYTE 8

// Lanes in the carry chain.
`define VMADD_LANES 8

// Element widths in bits.
`define VMADD_SEW8 8
`define VMADD_SEW16 16
`define VMADD_SEW32 32

// Element start marks per SEW, one bit per lane.
`define VMADD_START_SEW8 8'hFF
`define VMADD_START_SEW16 8'h55
`define VMADD_START_SEW32 8'h11

`endif
